// ==== mul_params.svh ====
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

////////////////////////////////////////////////////////////
// datapath geometry
////////////////////////////////////////////////////////////

`define MUL_XLEN 32
// must divide MUL_XLEN evenly
`define MUL_STAGES 4
`define MUL_SLICE (`MUL_XLEN / `MUL_STAGES)

////////////////////////////////////////////////////////////
// RV32M encodings, R-type
////////////////////////////////////////////////////////////

`define RV_OP_REG 7'b0110011
`define RV_F7_MULDIV 7'b0000001
`define RV_F3_MUL 3'b000
`define RV_F3_MULH 3'b001
`define RV_F3_MULHSU 3'b010
`define RV_F3_MULHU 3'b011

`endif

// ==== mul_pkg.sv ====
`include "mul_params.svh"

package mul_pkg;

    // request from the issuing stage
    typedef struct packed {
        logic [31:0]           instr;
        logic [`MUL_XLEN-1:0]  rs1_data;
        logic [`MUL_XLEN-1:0]  rs2_data;
    } md_req_t;

    // response back to writeback
    typedef struct packed {
        logic [4:0]            rd;
        logic [`MUL_XLEN-1:0]  result;
        logic                  illegal;
    } md_rsp_t;

    typedef struct packed {
        logic [`MUL_XLEN-1:0]  hi;
        logic [`MUL_XLEN-1:0]  lo;
    } md_words_t;

    // 64-bit product, whole accumulator or split words
    typedef union packed {
        logic [2*`MUL_XLEN-1:0] full;
        md_words_t              word;
    } md_product_u;

    // one slot of the multiply pipeline
    typedef struct packed {
        logic                  valid;
        logic [4:0]            rd;
        logic                  sel_hi;
        // result needs two's complement at the end
        logic                  negate;
        logic                  illegal;
        logic [`MUL_XLEN-1:0]  mcand;
        logic [`MUL_XLEN-1:0]  mplier;
        md_product_u           acc;
    } md_item_t;

endpackage

// ==== mul_decode_feed.sv ====
`timescale 1ns/1ns
`include "mul_params.svh"

module mul_decode_feed
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     adv_i,
    input  logic     req_valid_i,
    input  md_req_t  req_i,
    output md_item_t item_o
);

    logic [6:0]           opcode;
    logic [6:0]           funct7;
    logic [2:0]           funct3;
    logic                 a_signed;
    logic                 b_signed;
    logic                 sel_hi;
    logic                 illegal;
    logic                 a_neg;
    logic                 b_neg;
    logic [`MUL_XLEN-1:0] a_mag;
    logic [`MUL_XLEN-1:0] b_mag;
    md_item_t             item_d;
    md_item_t             data_q;
    logic                 valid_q;

    assign opcode = req_i.instr[6:0];
    assign funct3 = req_i.instr[14:12];
    assign funct7 = req_i.instr[31:25];

    ////////////////////////////////////////////////////////////
    // instruction decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        a_signed = 1'b0;
        b_signed = 1'b0;
        sel_hi   = 1'b0;
        illegal  = 1'b0;
        if (opcode != `RV_OP_REG || funct7 != `RV_F7_MULDIV) begin
            illegal = 1'b1;
        end else begin
            case (funct3)
                // low word is the same for any signedness
                `RV_F3_MUL: ;
                `RV_F3_MULH: begin
                    sel_hi   = 1'b1;
                    a_signed = 1'b1;
                    b_signed = 1'b1;
                end
                `RV_F3_MULHSU: begin
                    sel_hi   = 1'b1;
                    a_signed = 1'b1;
                end
                `RV_F3_MULHU: sel_hi = 1'b1;
                // div and rem land here too
                default: illegal = 1'b1;
            endcase
        end
    end

    // signed operands become magnitudes, sign kept aside
    assign a_neg = a_signed & req_i.rs1_data[`MUL_XLEN-1];
    assign b_neg = b_signed & req_i.rs2_data[`MUL_XLEN-1];
    assign a_mag = a_neg ? -req_i.rs1_data : req_i.rs1_data;
    assign b_mag = b_neg ? -req_i.rs2_data : req_i.rs2_data;

    always_comb begin
        item_d          = '0;
        item_d.valid    = req_valid_i;
        item_d.rd       = req_i.instr[11:7];
        item_d.sel_hi   = sel_hi;
        item_d.negate   = a_neg ^ b_neg;
        item_d.illegal  = illegal;
        item_d.mcand    = a_mag;
        item_d.mplier   = b_mag;
        item_d.acc.full = '0;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (adv_i) begin
            valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (adv_i) begin
            data_q <= item_d;
        end
    end

    always_comb begin
        item_o       = data_q;
        item_o.valid = valid_q;
    end

endmodule

// ==== mul_partial_stage.sv ====
`timescale 1ns/1ns
`include "mul_params.svh"

module mul_partial_stage
    import mul_pkg::*;
#(
    parameter int STAGE_IDX = 0
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     adv_i,
    input  md_item_t item_i,
    output md_item_t item_o
);

    // first multiplier bit owned by this stage
    localparam int BASE = STAGE_IDX * `MUL_SLICE;

    logic [2*`MUL_XLEN-1:0] sum;
    md_item_t               item_d;
    md_item_t               data_q;
    logic                   valid_q;

    ////////////////////////////////////////////////////////////
    // shift-and-add over this slice
    ////////////////////////////////////////////////////////////

    always_comb begin
        sum = item_i.acc.full;
        for (int b = 0; b < `MUL_SLICE; b++) begin
            if (item_i.mplier[BASE + b]) begin
                sum = sum + ({{`MUL_XLEN{1'b0}}, item_i.mcand} << (BASE + b));
            end
        end
        item_d = item_i;
        // illegal items keep their zero accumulator
        if (!item_i.illegal) begin
            item_d.acc.full = sum;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (adv_i) begin
            valid_q <= item_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (adv_i) begin
            data_q <= item_d;
        end
    end

    always_comb begin
        item_o       = data_q;
        item_o.valid = valid_q;
    end

endmodule

// ==== mul_result_drain.sv ====
`timescale 1ns/1ns
`include "mul_params.svh"

module mul_result_drain
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  md_item_t item_i,
    input  logic     rsp_ready_i,
    output logic     adv_o,
    output logic     rsp_valid_o,
    output md_rsp_t  rsp_o
);

    md_product_u          prod;
    logic [`MUL_XLEN-1:0] word;
    md_rsp_t              rsp_d;
    logic                 valid_q;
    md_rsp_t              rsp_q;

    ////////////////////////////////////////////////////////////
    // sign fix-up and word select
    ////////////////////////////////////////////////////////////

    always_comb begin
        prod.full = item_i.negate ? -item_i.acc.full : item_i.acc.full;
        if (item_i.illegal) begin
            word = '0;
        end else if (item_i.sel_hi) begin
            word = prod.word.hi;
        end else begin
            word = prod.word.lo;
        end
        rsp_d.rd      = item_i.rd;
        rsp_d.result  = word;
        rsp_d.illegal = item_i.illegal;
    end

    // whole pipe moves only when the output slot frees up
    assign adv_o = !valid_q || rsp_ready_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (adv_o) begin
            valid_q <= item_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (adv_o) begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_valid_o = valid_q;
    assign rsp_o       = rsp_q;

endmodule

// ==== mul_pipe_top.sv ====
`timescale 1ns/1ns
`include "mul_params.svh"

module mul_pipe_top
    import mul_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n_i,
    input  logic    req_valid_i,
    input  md_req_t req_i,
    output logic    req_ready_o,
    input  logic    rsp_ready_i,
    output logic    rsp_valid_o,
    output md_rsp_t rsp_o
);

    // items[0] from the feed, items[MUL_STAGES] into the drain
    md_item_t items [0:`MUL_STAGES];
    logic     adv;

    ////////////////////////////////////////////////////////////
    // front end
    ////////////////////////////////////////////////////////////

    mul_decode_feed u_feed (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .adv_i       (adv),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .item_o      (items[0])
    );

    // partial product chain
    for (genvar i = 0; i < `MUL_STAGES; i++) begin : g_stage
        mul_partial_stage #(
            .STAGE_IDX (i)
        ) u_stage (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .adv_i    (adv),
            .item_i   (items[i]),
            .item_o   (items[i+1])
        );
    end

    mul_result_drain u_drain (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .item_i      (items[`MUL_STAGES]),
        .rsp_ready_i (rsp_ready_i),
        .adv_o       (adv),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

    assign req_ready_o = adv;

endmodule

// ==== tb_mul_pipe.sv ====
`timescale 1ns/1ns
`include "mul_params.svh"

module tb_mul_pipe
    import mul_pkg::*;
;

    localparam int WAIT_LIMIT = 200;

    logic    clk = 1'b0;
    logic    arst_n_i;
    logic    req_valid_i;
    md_req_t req_i;
    logic    req_ready_o;
    logic    rsp_ready_i;
    logic    rsp_valid_o;
    md_rsp_t rsp_o;

    // expected responses in request order
    md_rsp_t exp_q [$];
    string   name_q [$];
    int      acc_q [$];
    bit      timed_q [$];

    int      errors = 0;
    int      timeouts = 0;
    int      cycle = 0;
    bit      abort = 1'b0;
    bit      rand_ready;
    bit      timed_mode;
    string   cur_name;
    bit      hold_prev = 1'b0;
    md_rsp_t prev_rsp;
    md_rsp_t exp_rsp;
    string   exp_name;
    int      exp_acc;
    bit      exp_timed;

    logic [31:0] corners [5] = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000, 32'h7fffffff};
    logic [2:0]  hi_f3 [3] = '{`RV_F3_MULH, `RV_F3_MULHSU, `RV_F3_MULHU};

    mul_pipe_top u_dut (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reference model and stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic md_rsp_t model_rsp(input logic [31:0] instr, input logic [31:0] a,
                                          input logic [31:0] b);
        logic [63:0] sa;
        logic [63:0] sb;
        logic [63:0] za;
        logic [63:0] zb;
        md_rsp_t     r;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        za = {32'h0, a};
        zb = {32'h0, b};
        r.rd = instr[11:7];
        r.result = '0;
        r.illegal = 1'b0;
        if (instr[6:0] != `RV_OP_REG || instr[31:25] != `RV_F7_MULDIV) begin
            r.illegal = 1'b1;
        end else begin
            // products taken mod 2^64 after sign or zero extension
            case (instr[14:12])
                `RV_F3_MUL:    r.result = 32'(za * zb);
                `RV_F3_MULH:   r.result = 32'((sa * sb) >> 32);
                `RV_F3_MULHSU: r.result = 32'((sa * zb) >> 32);
                `RV_F3_MULHU:  r.result = 32'((za * zb) >> 32);
                default:       r.illegal = 1'b1;
            endcase
        end
        return r;
    endfunction

    function automatic logic [31:0] make_instr(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [6:0] op);
        return {f7, 10'($urandom), f3, 5'($urandom), op};
    endfunction

    task automatic next_cycle();
        @(negedge clk);
        rsp_ready_i = rand_ready ? ($urandom_range(0, 3) != 0) : 1'b1;
    endtask

    task automatic idle_cycles(input int n);
        req_valid_i = 1'b0;
        repeat (n) next_cycle();
    endtask

    // call right after a falling edge
    task automatic send_req(input logic [31:0] instr, input logic [31:0] a,
                            input logic [31:0] b);
        int waited;
        waited = 0;
        if (abort) return;
        req_i.instr = instr;
        req_i.rs1_data = a;
        req_i.rs2_data = b;
        req_valid_i = 1'b1;
        #1;
        while (!req_ready_o && waited < WAIT_LIMIT) begin
            next_cycle();
            #1;
            waited++;
        end
        if (!req_ready_o) begin
            $display("timeout: request in %s was never accepted", cur_name);
            timeouts++;
            abort = 1'b1;
        end
        next_cycle();
        req_valid_i = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        req_valid_i = 1'b0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT && !abort) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() != 0 && !abort) begin
            $display("timeout: %0d responses never came back", exp_q.size());
            timeouts++;
            abort = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // scoreboard and checks
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (arst_n_i) begin
            if (req_valid_i && req_ready_o) begin
                exp_q.push_back(model_rsp(req_i.instr, req_i.rs1_data, req_i.rs2_data));
                name_q.push_back(cur_name);
                acc_q.push_back(cycle);
                timed_q.push_back(timed_mode);
            end
            if (hold_prev) begin
                assert (rsp_o == prev_rsp) else begin
                    errors++;
                    $display("CHECK FAILED rsp_stable expected %h actual %h", prev_rsp, rsp_o);
                end
            end
            if (rsp_valid_o && rsp_ready_i) begin
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("a response came back with no request outstanding");
                end
                if (exp_q.size() != 0) begin
                    exp_rsp = exp_q.pop_front();
                    exp_name = name_q.pop_front();
                    exp_acc = acc_q.pop_front();
                    exp_timed = timed_q.pop_front();
                    assert (rsp_o == exp_rsp) else begin
                        errors++;
                        $display("CHECK FAILED %s expected %h actual %h",
                                 exp_name, exp_rsp, rsp_o);
                    end
                    // visible after edge acc+STAGES+1 and consumed on the next edge
                    if (exp_timed) begin
                        assert (cycle - exp_acc == `MUL_STAGES + 2) else begin
                            errors++;
                            $display("CHECK FAILED %s latency expected %0d actual %0d",
                                     exp_name, `MUL_STAGES + 2, cycle - exp_acc);
                        end
                    end
                end
            end
            hold_prev = rsp_valid_o && !rsp_ready_i;
            prev_rsp = rsp_o;
            cycle++;
        end
    end

    // ready drops exactly while a response is held
    assert property (@(posedge clk) disable iff (!arst_n_i)
            req_ready_o == !(rsp_valid_o && !rsp_ready_i))
        else begin
            errors++;
            $display("CHECK FAILED req_ready expected %0b actual %0b",
                     !($sampled(rsp_valid_o) && !$sampled(rsp_ready_i)), $sampled(req_ready_o));
        end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h3285));
        arst_n_i = 1'b0;
        req_valid_i = 1'b0;
        req_i = '0;
        rsp_ready_i = 1'b1;
        rand_ready = 1'b0;
        timed_mode = 1'b0;
        cur_name = "reset";
        repeat (4) @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);
        assert (!rsp_valid_o && req_ready_o) else begin
            errors++;
            $display("CHECK FAILED after_reset expected valid 0 ready 1 actual valid %0b ready %0b",
                     rsp_valid_o, req_ready_o);
        end

        timed_mode = 1'b1;
        cur_name = "mul_back_to_back";
        for (int i = 0; i < 16; i++) begin
            send_req(make_instr(`RV_F7_MULDIV, `RV_F3_MUL, `RV_OP_REG), $urandom, $urandom);
        end
        drain();
        timed_mode = 1'b0;

        for (int f = 0; f < 3; f++) begin
            cur_name = $sformatf("high_word_f3_%0d", hi_f3[f]);
            foreach (corners[i]) begin
                foreach (corners[j]) begin
                    send_req(make_instr(`RV_F7_MULDIV, hi_f3[f], `RV_OP_REG),
                             corners[i], corners[j]);
                end
            end
            repeat (30) begin
                send_req(make_instr(`RV_F7_MULDIV, hi_f3[f], `RV_OP_REG), $urandom, $urandom);
            end
        end
        drain();

        // wrong opcode, funct7 and division funct3 interleaved with legal ones
        cur_name = "illegal_mix";
        for (int i = 0; i < 8; i++) begin
            send_req(make_instr(`RV_F7_MULDIV, `RV_F3_MUL, 7'b0010011), $urandom, $urandom);
            send_req(make_instr(7'b0100000, `RV_F3_MULH, `RV_OP_REG), $urandom, $urandom);
            send_req(make_instr(`RV_F7_MULDIV, 3'(4 + i % 4), `RV_OP_REG), $urandom, $urandom);
            send_req(make_instr(`RV_F7_MULDIV, `RV_F3_MULHU, `RV_OP_REG), $urandom, $urandom);
        end
        drain();

        rand_ready = 1'b1;
        cur_name = "random_flow";
        for (int i = 0; i < 150; i++) begin
            idle_cycles($urandom_range(0, 2));
            send_req(make_instr(($urandom_range(0, 9) == 0) ? 7'b0100000 : `RV_F7_MULDIV,
                                3'($urandom_range(0, 7)), `RV_OP_REG), $urandom, $urandom);
        end
        drain();
        rand_ready = 1'b0;
        idle_cycles(4);

        $display("checks failed: %0d, timeouts: %0d, responses left: %0d",
                 errors, timeouts, exp_q.size());
        if (errors == 0 && timeouts == 0 && exp_q.size() == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+.
mul_pkg.sv
mul_decode_feed.sv
mul_partial_stage.sv
mul_result_drain.sv
mul_pipe_top.sv
tb_mul_pipe.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_mul_pipe -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
